// File: list.f
src/clint_pkg.sv
src/clint_bus_slave.sv
src/clint_timer.sv
src/clint_regs.sv
src/clint_top.sv
test/clint_checker.sv
test/tb_clint.sv

// File: run.sh
#!/bin/sh
# Builds the CLINT testbench with Verilator, runs it and checks the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_clint -Mdir obj_dir

sim_out=$(./obj_dir/Vtb_clint)
echo "$sim_out"

if echo "$sim_out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

// File: src/clint_bus_slave.sv
// Request/response slave port: queues credited requests, issues one per cycle to the register block
module clint_bus_slave (
    input  logic                               i_clk,
    input  logic                               i_nrst,
    input  logic                               i_req_valid,
    input  clint_pkg::bus_op_e                 i_req_op,
    input  logic [clint_pkg::ADDR_BITS-1:0]    i_req_addr,
    input  logic [clint_pkg::DATA_BITS-1:0]    i_req_wdata,
    input  logic [clint_pkg::STRB_BITS-1:0]    i_req_wstrb,
    input  logic [clint_pkg::DATA_BITS-1:0]    i_rd_data,
    input  logic                               i_rd_err,
    output logic                               o_req_credit,
    output logic                               o_iss_valid,
    output clint_pkg::bus_op_e                 o_iss_op,
    output logic [clint_pkg::ADDR_BITS-1:0]    o_iss_addr,
    output logic [clint_pkg::DATA_BITS-1:0]    o_iss_wdata,
    output logic [clint_pkg::STRB_BITS-1:0]    o_iss_wstrb,
    output logic                               o_rsp_valid,
    output logic [clint_pkg::DATA_BITS-1:0]    o_rsp_rdata,
    output logic                               o_rsp_err
);

    // Request storage
    clint_pkg::bus_op_e                 fifo_op    [clint_pkg::REQ_DEPTH];
    logic [clint_pkg::ADDR_BITS-1:0]    fifo_addr  [clint_pkg::REQ_DEPTH];
    logic [clint_pkg::DATA_BITS-1:0]    fifo_wdata [clint_pkg::REQ_DEPTH];
    logic [clint_pkg::STRB_BITS-1:0]    fifo_wstrb [clint_pkg::REQ_DEPTH];

    logic [clint_pkg::REQ_PTR_BITS-1:0] wr_ptr;
    logic [clint_pkg::REQ_PTR_BITS-1:0] rd_ptr;
    logic [clint_pkg::REQ_CNT_BITS-1:0] count;
    logic                               pop;
    logic                               rsp_pending;

    function automatic logic [clint_pkg::REQ_PTR_BITS-1:0] next_ptr(
        input logic [clint_pkg::REQ_PTR_BITS-1:0] ptr
    );
        if (ptr == clint_pkg::REQ_PTR_BITS'(clint_pkg::REQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + clint_pkg::REQ_PTR_BITS'(1);
    endfunction

    assign pop = (count != '0);             // Drain whenever something is queued

    // Credits guarantee a free slot, so a push never checks for full
    always_ff @(posedge i_clk) begin
        if (i_req_valid) begin
            fifo_op[wr_ptr]    <= i_req_op;
            fifo_addr[wr_ptr]  <= i_req_addr;
            fifo_wdata[wr_ptr] <= i_req_wdata;
            fifo_wstrb[wr_ptr] <= i_req_wstrb;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            rsp_pending <= 1'b0;
        end else begin
            if (i_req_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (i_req_valid && !pop) begin
                count <= count + clint_pkg::REQ_CNT_BITS'(1);
            end else if (!i_req_valid && pop) begin
                count <= count - clint_pkg::REQ_CNT_BITS'(1);
            end
            rsp_pending <= pop;             // Register block answers one cycle later
        end
    end

    // Head of the FIFO goes straight to the register block
    assign o_iss_valid  = pop;
    assign o_iss_op     = fifo_op[rd_ptr];
    assign o_iss_addr   = fifo_addr[rd_ptr];
    assign o_iss_wdata  = fifo_wdata[rd_ptr];
    assign o_iss_wstrb  = fifo_wstrb[rd_ptr];
    assign o_req_credit = pop;              // Slot freed on every issue

    // In-order response, no back-pressure
    assign o_rsp_valid = rsp_pending;
    assign o_rsp_rdata = i_rd_data;
    assign o_rsp_err   = i_rd_err;

endmodule

// File: src/clint_pkg.sv
// Shared widths, opcodes, region encodings and address fields for the CLINT, used by scoped name
package clint_pkg;

    // Core sizing
    localparam int HART_COUNT = 4;
    localparam int ADDR_BITS  = 16;
    localparam int DATA_BITS  = 64;
    localparam int STRB_BITS  = DATA_BITS / 8;

    // Request FIFO depth equals the credits owned by the requester after reset
    localparam int REQ_DEPTH    = 2;
    localparam int REQ_PTR_BITS = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int REQ_CNT_BITS = $clog2(REQ_DEPTH + 1);

    // Word index field, region sits in the bits above it
    localparam int INDEX_LSB  = 3;
    localparam int INDEX_MSB  = 13;
    localparam int INDEX_BITS = INDEX_MSB - INDEX_LSB + 1;

    // Last word of region 2
    localparam logic [INDEX_BITS-1:0] MTIME_INDEX = 'h7FF;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // Address bits 15:14
    typedef enum logic [1:0] {
        REGION_MSIP     = 2'd0,     // Two harts per word
        REGION_MTIMECMP = 2'd1,     // One hart per word
        REGION_MTIME    = 2'd2,     // Read-only timer
        REGION_NONE     = 2'd3
    } clint_region_e;

endpackage

// File: src/clint_regs.sv
// CLINT register block: decodes issued accesses, holds msip and mtimecmp, returns read data
module clint_regs (
    input  logic                                                   i_clk,
    input  logic                                                   i_nrst,
    input  logic                                                   i_iss_valid,
    input  clint_pkg::bus_op_e                                     i_iss_op,
    input  logic [clint_pkg::ADDR_BITS-1:0]                        i_iss_addr,
    input  logic [clint_pkg::DATA_BITS-1:0]                        i_iss_wdata,
    input  logic [clint_pkg::STRB_BITS-1:0]                        i_iss_wstrb,
    input  logic [clint_pkg::DATA_BITS-1:0]                        i_mtime,
    output logic [clint_pkg::DATA_BITS-1:0]                        o_rd_data,
    output logic                                                   o_rd_err,
    output logic [clint_pkg::HART_COUNT-1:0]                       o_msip,
    output logic [clint_pkg::HART_COUNT-1:0][clint_pkg::DATA_BITS-1:0] o_mtimecmp
);

    localparam int HALF_DATA = clint_pkg::DATA_BITS / 2;
    localparam int HALF_STRB = clint_pkg::STRB_BITS / 2;

    clint_pkg::clint_region_e                                region;
    logic [clint_pkg::INDEX_BITS-1:0]                        index;
    logic [clint_pkg::INDEX_BITS:0]                          hart_hi;
    logic                                                    acc_err;
    logic                                                    wr_en;
    logic [clint_pkg::DATA_BITS-1:0]                         rd_next;
    logic [clint_pkg::HART_COUNT-1:0]                        msip_q;
    logic [clint_pkg::HART_COUNT-1:0][clint_pkg::DATA_BITS-1:0] cmp_q;

    // Region in the bits above the word index
    assign region  = clint_pkg::clint_region_e'(
                         i_iss_addr[clint_pkg::ADDR_BITS-1:clint_pkg::INDEX_MSB+1]);
    assign index   = i_iss_addr[clint_pkg::INDEX_MSB:clint_pkg::INDEX_LSB];
    assign hart_hi = {index, 1'b1};         // Upper hart of an msip pair
    assign wr_en   = i_iss_valid && (i_iss_op == clint_pkg::OP_WRITE) && !acc_err;

    // Decode and read mux, data stays zero on error
    always_comb begin
        acc_err = 1'b0;
        rd_next = '0;
        case (region)
            clint_pkg::REGION_MSIP: begin
                if (int'(hart_hi) >= clint_pkg::HART_COUNT) begin
                    acc_err = 1'b1;
                end else begin
                    for (int h = 0; h < clint_pkg::HART_COUNT; h++) begin
                        if ((h / 2) == int'(index)) begin
                            rd_next[(h % 2) * HALF_DATA] = msip_q[h];   // Bit 0 or bit 32
                        end
                    end
                end
            end
            clint_pkg::REGION_MTIMECMP: begin
                if (int'(index) >= clint_pkg::HART_COUNT) begin
                    acc_err = 1'b1;
                end else begin
                    for (int h = 0; h < clint_pkg::HART_COUNT; h++) begin
                        if (h == int'(index)) begin
                            rd_next = cmp_q[h];
                        end
                    end
                end
            end
            clint_pkg::REGION_MTIME: begin
                if (index != clint_pkg::MTIME_INDEX) begin
                    acc_err = 1'b1;
                end else begin
                    rd_next = i_mtime;      // Read-only
                end
            end
            default: begin
                acc_err = 1'b1;             // Unmapped region
            end
        endcase
    end

    // Register updates, mtime writes fall through without effect
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            msip_q <= '0;
            cmp_q  <= '1;                   // Compare far away, no timer pending
        end else if (wr_en) begin
            for (int h = 0; h < clint_pkg::HART_COUNT; h++) begin
                if (region == clint_pkg::REGION_MSIP && (h / 2) == int'(index)) begin
                    if (|i_iss_wstrb[(h % 2) * HALF_STRB +: HALF_STRB]) begin
                        msip_q[h] <= i_iss_wdata[(h % 2) * HALF_DATA];
                    end
                end
                if (region == clint_pkg::REGION_MTIMECMP && h == int'(index)) begin
                    for (int b = 0; b < clint_pkg::STRB_BITS; b++) begin
                        if (i_iss_wstrb[b]) begin
                            cmp_q[h][b*8 +: 8] <= i_iss_wdata[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

    // Captured on every issue, old contents seen by a read
    always_ff @(posedge i_clk) begin
        if (i_iss_valid) begin
            o_rd_data <= (i_iss_op == clint_pkg::OP_WRITE) ? '0 : rd_next;  // Writes answer zero
            o_rd_err  <= acc_err;
        end
    end

    assign o_msip     = msip_q;
    assign o_mtimecmp = cmp_q;

endmodule

// File: src/clint_timer.sv
// Free-running machine timer with per-hart compare, drives the timer-pending lines
module clint_timer (
    input  logic                                                  i_clk,
    input  logic                                                  i_nrst,
    input  logic [clint_pkg::HART_COUNT-1:0][clint_pkg::DATA_BITS-1:0] i_mtimecmp,
    output logic [clint_pkg::DATA_BITS-1:0]                       o_mtime,
    output logic [clint_pkg::HART_COUNT-1:0]                      o_mtip
);

    logic [clint_pkg::DATA_BITS-1:0]  mtime_q;
    logic [clint_pkg::HART_COUNT-1:0] mtip_q;
    logic [clint_pkg::HART_COUNT-1:0] cmp_hit;

    // Unsigned compare of the current count against each hart
    always_comb begin
        for (int h = 0; h < clint_pkg::HART_COUNT; h++) begin
            cmp_hit[h] = (mtime_q >= i_mtimecmp[h]);
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            mtime_q <= '0;
            mtip_q  <= '0;
        end else begin
            mtime_q <= mtime_q + clint_pkg::DATA_BITS'(1);  // One tick per clock
            mtip_q  <= cmp_hit;             // Pending follows the compare a cycle late
        end
    end

    assign o_mtime = mtime_q;
    assign o_mtip  = mtip_q;

endmodule

// File: src/clint_top.sv
// CLINT top level: credit-based slave port, register block and machine timer wired together
module clint_top (
    input  logic                               i_clk,
    input  logic                               i_nrst,
    input  logic                               i_req_valid,
    input  clint_pkg::bus_op_e                 i_req_op,
    input  logic [clint_pkg::ADDR_BITS-1:0]    i_req_addr,
    input  logic [clint_pkg::DATA_BITS-1:0]    i_req_wdata,
    input  logic [clint_pkg::STRB_BITS-1:0]    i_req_wstrb,
    output logic                               o_req_credit,
    output logic                               o_rsp_valid,
    output logic [clint_pkg::DATA_BITS-1:0]    o_rsp_rdata,
    output logic                               o_rsp_err,
    output logic [clint_pkg::HART_COUNT-1:0]   o_msip,
    output logic [clint_pkg::HART_COUNT-1:0]   o_mtip,
    output logic [clint_pkg::DATA_BITS-1:0]    o_mtimer
);

    // Issue path from the slave
    logic                                                   iss_valid;
    clint_pkg::bus_op_e                                     iss_op;
    logic [clint_pkg::ADDR_BITS-1:0]                        iss_addr;
    logic [clint_pkg::DATA_BITS-1:0]                        iss_wdata;
    logic [clint_pkg::STRB_BITS-1:0]                        iss_wstrb;

    // Read return and timer links
    logic [clint_pkg::DATA_BITS-1:0]                        rd_data;
    logic                                                   rd_err;
    logic [clint_pkg::HART_COUNT-1:0][clint_pkg::DATA_BITS-1:0] mtimecmp;

    clint_bus_slave u_slave (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req_op     (i_req_op),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .i_req_wstrb  (i_req_wstrb),
        .i_rd_data    (rd_data),
        .i_rd_err     (rd_err),
        .o_req_credit (o_req_credit),
        .o_iss_valid  (iss_valid),
        .o_iss_op     (iss_op),
        .o_iss_addr   (iss_addr),
        .o_iss_wdata  (iss_wdata),
        .o_iss_wstrb  (iss_wstrb),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_rdata  (o_rsp_rdata),
        .o_rsp_err    (o_rsp_err)
    );

    clint_regs u_regs (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_iss_valid  (iss_valid),
        .i_iss_op     (iss_op),
        .i_iss_addr   (iss_addr),
        .i_iss_wdata  (iss_wdata),
        .i_iss_wstrb  (iss_wstrb),
        .i_mtime      (o_mtimer),           // Timer value for region 2 reads
        .o_rd_data    (rd_data),
        .o_rd_err     (rd_err),
        .o_msip       (o_msip),
        .o_mtimecmp   (mtimecmp)
    );

    clint_timer u_timer (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_mtimecmp   (mtimecmp),
        .o_mtime      (o_mtimer),
        .o_mtip       (o_mtip)
    );

endmodule

// File: test/clint_checker.sv
// Assertion module bound to the CLINT top level, checks request credits, responses and mtime
module clint_checker (
    input logic                            i_clk,
    input logic                            i_nrst,
    input logic                            i_req_valid,
    input logic                            o_req_credit,
    input logic                            o_rsp_valid,
    input logic [clint_pkg::DATA_BITS-1:0] o_mtimer
);
    timeunit 1ns;
    timeprecision 100ps;

    int credits;                            // Credits held by the requester
    int outstanding;                        // Requests still waiting for a response

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            credits     <= clint_pkg::REQ_DEPTH;
            outstanding <= 0;
        end else begin
            credits     <= credits + int'(o_req_credit) - int'(i_req_valid);
            outstanding <= outstanding + int'(i_req_valid) - int'(o_rsp_valid);
        end
    end

    // A credit returned in this cycle may be spent in the same cycle
    credit_avail: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_req_valid |-> (credits + int'(o_req_credit)) > 0)
        else $error("request sent with no credit left");

    rsp_after_issue: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_rsp_valid |-> outstanding > 0)
        else $error("response with no request outstanding");

    mtime_step: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $past(i_nrst) |-> (o_mtimer == $past(o_mtimer) + 64'd1))
        else $error("mtime did not advance by one");

endmodule

bind clint_top clint_checker u_checker (
    .i_clk        (i_clk),
    .i_nrst       (i_nrst),
    .i_req_valid  (i_req_valid),
    .o_req_credit (o_req_credit),
    .o_rsp_valid  (o_rsp_valid),
    .o_mtimer     (o_mtimer)
);

// File: test/tb_clint.sv
// Testbench for clint_top: credit-aware requester, reference model and response compare
module tb_clint;
    timeunit 1ns;
    timeprecision 100ps;

    logic                                  i_clk;
    logic                                  i_nrst;
    logic                                  i_req_valid;
    clint_pkg::bus_op_e                    i_req_op;
    logic [clint_pkg::ADDR_BITS-1:0]       i_req_addr;
    logic [clint_pkg::DATA_BITS-1:0]       i_req_wdata;
    logic [clint_pkg::STRB_BITS-1:0]       i_req_wstrb;
    logic                                  o_req_credit;
    logic                                  o_rsp_valid;
    logic [clint_pkg::DATA_BITS-1:0]       o_rsp_rdata;
    logic                                  o_rsp_err;
    logic [clint_pkg::HART_COUNT-1:0]      o_msip;
    logic [clint_pkg::HART_COUNT-1:0]      o_mtip;
    logic [clint_pkg::DATA_BITS-1:0]       o_mtimer;

    // Reference model state
    logic [clint_pkg::HART_COUNT-1:0]      model_msip;
    logic [clint_pkg::DATA_BITS-1:0]       model_cmp [clint_pkg::HART_COUNT];

    // Expected responses, one entry per request
    logic [clint_pkg::DATA_BITS-1:0]       exp_data_q [$];
    logic                                  exp_err_q [$];
    logic                                  exp_mtime_q [$];
    logic [clint_pkg::HART_COUNT-1:0]      exp_msip_q [$];

    logic [31:0]                           lfsr_state;
    logic [clint_pkg::DATA_BITS-1:0]       last_mtime;
    int                                    credits;
    int                                    num_checks;
    int                                    data_errs;
    int                                    flag_errs;
    int                                    hart_errs;
    int                                    other_errs;

    clint_top UUT (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req_op     (i_req_op),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .i_req_wstrb  (i_req_wstrb),
        .o_req_credit (o_req_credit),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_rdata  (o_rsp_rdata),
        .o_rsp_err    (o_rsp_err),
        .o_msip       (o_msip),
        .o_mtip       (o_mtip),
        .o_mtimer     (o_mtimer)
    );

    always #50 i_clk = ~i_clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];
        end
        return v;
    endfunction

    function automatic logic [clint_pkg::ADDR_BITS-1:0] reg_addr(
        input clint_pkg::clint_region_e region,
        input int                       idx
    );
        logic [clint_pkg::ADDR_BITS-1:0] a;
        a = '0;
        a[clint_pkg::ADDR_BITS-1:clint_pkg::INDEX_MSB+1] = region;
        a[clint_pkg::INDEX_MSB:clint_pkg::INDEX_LSB] = clint_pkg::INDEX_BITS'(idx);
        return a;
    endfunction

    // Applies one access to the model and gives the expected read data and error flag
    function automatic void ref_access(
        input  clint_pkg::bus_op_e              op,
        input  logic [clint_pkg::ADDR_BITS-1:0] addr,
        input  logic [clint_pkg::DATA_BITS-1:0] wdata,
        input  logic [clint_pkg::STRB_BITS-1:0] wstrb,
        output logic [clint_pkg::DATA_BITS-1:0] data,
        output logic                            err
    );
        clint_pkg::clint_region_e region;
        int                       index;
        data   = '0;
        err    = 1'b0;
        region = clint_pkg::clint_region_e'(addr[clint_pkg::ADDR_BITS-1:clint_pkg::INDEX_MSB+1]);
        index  = int'(addr[clint_pkg::INDEX_MSB:clint_pkg::INDEX_LSB]);
        case (region)
            clint_pkg::REGION_MSIP: begin
                if (2 * index + 1 >= clint_pkg::HART_COUNT) begin
                    err = 1'b1;                 // Pair reaches past the last hart
                end else if (op == clint_pkg::OP_READ) begin
                    data[0] = model_msip[2 * index];
                    data[clint_pkg::DATA_BITS / 2] = model_msip[2 * index + 1];
                end else begin
                    if (|wstrb[0 +: clint_pkg::STRB_BITS / 2]) begin
                        model_msip[2 * index] = wdata[0];
                    end
                    if (|wstrb[clint_pkg::STRB_BITS / 2 +: clint_pkg::STRB_BITS / 2]) begin
                        model_msip[2 * index + 1] = wdata[clint_pkg::DATA_BITS / 2];
                    end
                end
            end
            clint_pkg::REGION_MTIMECMP: begin
                if (index >= clint_pkg::HART_COUNT) begin
                    err = 1'b1;
                end else if (op == clint_pkg::OP_READ) begin
                    data = model_cmp[index];
                end else begin
                    for (int b = 0; b < clint_pkg::STRB_BITS; b++) begin
                        if (wstrb[b]) model_cmp[index][b*8 +: 8] = wdata[b*8 +: 8];
                    end
                end
            end
            clint_pkg::REGION_MTIME: err = (index != int'(clint_pkg::MTIME_INDEX));
            default: err = 1'b1;
        endcase
    endfunction

    // Every wait in the driver goes through here so no returned credit is missed
    task automatic next_cycle();
        @(negedge i_clk);
        i_req_valid = 1'b0;
        if (o_req_credit) credits++;
    endtask

    task automatic send_req(
        input clint_pkg::bus_op_e              op,
        input logic [clint_pkg::ADDR_BITS-1:0] addr,
        input logic [clint_pkg::DATA_BITS-1:0] wdata,
        input logic [clint_pkg::STRB_BITS-1:0] wstrb
    );
        logic [clint_pkg::DATA_BITS-1:0] data;
        logic                            err;
        int                              waited;
        waited = 0;
        next_cycle();
        while (credits == 0 && waited < 50) begin
            next_cycle();
            waited++;
        end
        if (credits == 0) begin
            $display("Timeout: no request credit came back within 50 cycles");
            other_errs++;
            return;
        end
        ref_access(op, addr, wdata, wstrb, data, err);
        exp_data_q.push_back(data);
        exp_err_q.push_back(err);
        exp_mtime_q.push_back(op == clint_pkg::OP_READ && !err &&
            addr[clint_pkg::ADDR_BITS-1:clint_pkg::INDEX_MSB+1] == clint_pkg::REGION_MTIME);
        exp_msip_q.push_back(model_msip);
        i_req_valid = 1'b1;
        i_req_op    = op;
        i_req_addr  = addr;
        i_req_wdata = wdata;
        i_req_wstrb = wstrb;
        credits--;
    endtask

    task automatic wait_mtip(input int hart, input logic level);
        int waited;
        waited = 0;
        while (o_mtip[hart] !== level && waited < 20) begin
            next_cycle();
            waited++;
        end
        if (o_mtip[hart] !== level) begin
            $display("Timeout: o_mtip[%0d] did not reach %b within 20 cycles", hart, level);
            other_errs++;
        end
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (exp_err_q.size() != 0 && waited < 50) begin
            next_cycle();
            waited++;
        end
        if (exp_err_q.size() != 0) begin
            $display("Timeout: %0d responses still missing after 50 cycles", exp_err_q.size());
            other_errs++;
        end
    endtask

    task automatic check_data(input logic [clint_pkg::DATA_BITS-1:0] got,
                              input logic [clint_pkg::DATA_BITS-1:0] exp, input string what);
        num_checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        num_checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
            flag_errs++;
        end
    endtask

    task automatic check_harts(input logic [clint_pkg::HART_COUNT-1:0] got,
                               input logic [clint_pkg::HART_COUNT-1:0] exp, input string what);
        num_checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
            hart_errs++;
        end
    endtask

    // mtime must move forward and cannot pass the live timer
    task automatic check_mtime(input logic [clint_pkg::DATA_BITS-1:0] got,
                               input logic [clint_pkg::DATA_BITS-1:0] prev,
                               input logic [clint_pkg::DATA_BITS-1:0] now);
        num_checks++;
        if (!(got > prev && got <= now)) begin
            $display("[ERROR] %0t: mtime read %h outside (%h, %h]", $time, got, prev, now);
            data_errs++;
        end
    endtask

    // Response compare, sampled on the falling edge where outputs are settled
    always @(negedge i_clk) begin : compare_rsp
        logic [clint_pkg::DATA_BITS-1:0] data;
        logic                            err;
        logic                            is_mtime;
        if (i_nrst && o_rsp_valid) begin
            if (exp_err_q.size() == 0) begin
                $display("A response arrived with no request outstanding");
                other_errs++;
            end else begin
                data     = exp_data_q.pop_front();
                err      = exp_err_q.pop_front();
                is_mtime = exp_mtime_q.pop_front();
                check_flag(o_rsp_err, err, "response error flag");
                if (is_mtime) begin
                    check_mtime(o_rsp_rdata, last_mtime, o_mtimer);
                    last_mtime = o_rsp_rdata;
                end else begin
                    check_data(o_rsp_rdata, data, "response data");
                end
                check_harts(o_msip, exp_msip_q.pop_front(), "o_msip");
            end
        end
    end

    initial begin : watchdog
        #2000000;
        $display("The simulation ran past its time limit");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [clint_pkg::ADDR_BITS-1:0] burst [8];
        int                              target;
        i_clk       = 1'b0;
        i_nrst      = 1'b0;
        i_req_valid = 1'b0;
        i_req_op    = clint_pkg::OP_READ;
        i_req_addr  = '0;
        i_req_wdata = '0;
        i_req_wstrb = '0;
        lfsr_state  = 32'h30040150;
        model_msip  = '0;
        last_mtime  = '0;
        credits     = clint_pkg::REQ_DEPTH;
        num_checks  = 0;
        data_errs   = 0;
        flag_errs   = 0;
        hart_errs   = 0;
        other_errs  = 0;
        for (int h = 0; h < clint_pkg::HART_COUNT; h++) model_cmp[h] = '1;
        for (int i = 0; i < 10; i++) next_cycle();
        i_nrst = 1'b1;
        next_cycle();

        // Reset values
        check_harts(o_msip, '0, "o_msip after reset");
        check_harts(o_mtip, '0, "o_mtip after reset");
        for (int h = 0; h < clint_pkg::HART_COUNT; h++) begin
            send_req(clint_pkg::OP_READ, reg_addr(clint_pkg::REGION_MTIMECMP, h), '0, '0);
        end

        // msip writes under random strobes
        for (int i = 0; i < 12; i++) begin
            send_req(clint_pkg::OP_WRITE, reg_addr(clint_pkg::REGION_MSIP, int'(rand_bits(1))),
                     rand_bits(64), clint_pkg::STRB_BITS'(rand_bits(8)));
            send_req(clint_pkg::OP_READ, reg_addr(clint_pkg::REGION_MSIP, int'(rand_bits(1))),
                     '0, '0);
        end

        // mtimecmp byte merge
        for (int i = 0; i < 12; i++) begin
            send_req(clint_pkg::OP_WRITE, reg_addr(clint_pkg::REGION_MTIMECMP, int'(rand_bits(2))),
                     rand_bits(64), clint_pkg::STRB_BITS'(rand_bits(8)));
        end
        for (int h = 0; h < clint_pkg::HART_COUNT; h++) begin
            send_req(clint_pkg::OP_READ, reg_addr(clint_pkg::REGION_MTIMECMP, h), '0, '0);
        end

        // mtime reads, the write in between is dropped without error
        send_req(clint_pkg::OP_READ,
                 reg_addr(clint_pkg::REGION_MTIME, int'(clint_pkg::MTIME_INDEX)), '0, '0);
        send_req(clint_pkg::OP_WRITE,
                 reg_addr(clint_pkg::REGION_MTIME, int'(clint_pkg::MTIME_INDEX)), '0, '1);
        send_req(clint_pkg::OP_READ,
                 reg_addr(clint_pkg::REGION_MTIME, int'(clint_pkg::MTIME_INDEX)), '0, '0);

        // Timer interrupt on one hart, others parked at all ones
        for (int h = 0; h < clint_pkg::HART_COUNT; h++) begin
            send_req(clint_pkg::OP_WRITE, reg_addr(clint_pkg::REGION_MTIMECMP, h), '1, '1);
        end
        drain_responses();
        target = int'(rand_bits(2));
        send_req(clint_pkg::OP_WRITE, reg_addr(clint_pkg::REGION_MTIMECMP, target), '0, '1);
        wait_mtip(target, 1'b1);
        check_harts(o_mtip, clint_pkg::HART_COUNT'(1 << target), "o_mtip after compare hit");
        send_req(clint_pkg::OP_WRITE, reg_addr(clint_pkg::REGION_MTIMECMP, target), '1, '1);
        wait_mtip(target, 1'b0);
        check_harts(o_mtip, '0, "o_mtip after compare cleared");

        // Error accesses mixed with good reads, sent back to back
        burst[0] = reg_addr(clint_pkg::REGION_MSIP, 2);
        burst[1] = reg_addr(clint_pkg::REGION_MTIMECMP, 0);
        burst[2] = reg_addr(clint_pkg::REGION_MTIMECMP, clint_pkg::HART_COUNT);
        burst[3] = reg_addr(clint_pkg::REGION_MSIP, 1);
        burst[4] = reg_addr(clint_pkg::REGION_MTIME, 0);
        burst[5] = reg_addr(clint_pkg::REGION_MTIMECMP, 3);
        burst[6] = reg_addr(clint_pkg::REGION_NONE, 5);
        burst[7] = reg_addr(clint_pkg::REGION_MSIP, 0);
        for (int i = 0; i < 8; i++) send_req(clint_pkg::OP_READ, burst[i], '0, '0);
        send_req(clint_pkg::OP_WRITE, burst[0], '1, '1);
        drain_responses();
        if (credits != clint_pkg::REQ_DEPTH) begin
            $display("The requester ended with %0d credits instead of %0d",
                     credits, clint_pkg::REQ_DEPTH);
            other_errs++;
        end

        $display("Checks %0d, errors: data %0d, flag %0d, hart vector %0d, other %0d",
                 num_checks, data_errs, flag_errs, hart_errs, other_errs);
        if (data_errs + flag_errs + hart_errs + other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
